/* Bender.yml */
package:
  name: htif_bridge

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/htif_pkg.sv
      - hdl/axi_htif_router.sv
      - hdl/htif_ctrl.sv
      - hdl/htif_regs.sv
      - hdl/uart_lite_master.sv
      - hdl/htif_bridge.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - tests/htif_bridge_checker.sv
      - tests/htif_bridge_tb.sv

/* compile.f */
+incdir+hdl
hdl/htif_pkg.sv
hdl/axi_htif_router.sv
hdl/htif_ctrl.sv
hdl/htif_regs.sv
hdl/uart_lite_master.sv
hdl/htif_bridge.sv
tests/htif_bridge_checker.sv
tests/htif_bridge_tb.sv

/* hdl/axi_htif_router.sv */
// HTIF router
// spots single-beat TOHOST/FROMHOST requests and steers each AXI channel
// to downstream, the local HTIF slave or the UART master
`timescale 1ns/100ps
`include "htif_params.svh"

module axi_htif_router (
    // upstream
    input  htif_pkg::addr_t up_awaddr, up_araddr,
    input  htif_pkg::len_t up_awlen, up_arlen,
    input  logic up_awvalid, up_wvalid, up_wlast, up_bready, up_arvalid, up_rready,
    input  htif_pkg::data_t up_wdata,
    input  htif_pkg::strb_t up_wstrb,
    output logic up_awready, up_wready, up_bvalid, up_arready, up_rvalid, up_rlast,
    output htif_pkg::data_t up_rdata,
    // downstream
    output htif_pkg::addr_t dn_awaddr, dn_araddr,
    output htif_pkg::len_t dn_awlen, dn_arlen,
    output logic dn_awvalid, dn_wvalid, dn_wlast, dn_bready, dn_arvalid, dn_rready,
    output htif_pkg::data_t dn_wdata,
    output htif_pkg::strb_t dn_wstrb,
    input  logic dn_awready, dn_wready, dn_bvalid, dn_arready, dn_rvalid, dn_rlast,
    input  htif_pkg::data_t dn_rdata,
    // local HTIF slave
    output logic loc_arvalid, loc_ar_fr, loc_awvalid, loc_aw_fr, loc_wvalid,
    input  logic loc_awready, loc_wready, loc_arready, loc_bvalid, loc_rvalid, loc_rlast,
    input  htif_pkg::data_t loc_rdata,
    // UART master requests
    input  htif_pkg::addr_t ua_araddr, ua_awaddr,
    input  logic ua_arvalid, ua_awvalid, ua_wvalid, ua_wlast, ua_bready, ua_rready,
    input  htif_pkg::data_t ua_wdata,
    input  htif_pkg::strb_t ua_wstrb,
    input  logic on_htif,
    output logic use_htif
);
    logic ar_to, ar_fr, aw_to, aw_fr, htif_hit;

    assign ar_to = up_araddr == `HTIF_TOHOST_ADDR;
    assign ar_fr = up_araddr == `HTIF_FRHOST_ADDR;
    assign aw_to = up_awaddr == `HTIF_TOHOST_ADDR;
    assign aw_fr = up_awaddr == `HTIF_FRHOST_ADDR;

    assign htif_hit = up_arvalid & (up_arlen == '0) & (ar_to | ar_fr)
                    | up_awvalid & (up_awlen == '0) & (aw_to | aw_fr);
    assign use_htif = htif_hit | on_htif;

    assign loc_arvalid = use_htif & up_arvalid;
    assign loc_awvalid = use_htif & up_awvalid;
    assign loc_wvalid = use_htif & up_wvalid;
    assign loc_ar_fr = ar_fr;
    assign loc_aw_fr = aw_fr;

    // upstream side
    assign up_awready = use_htif ? loc_awready : dn_awready;
    assign up_wready = use_htif ? loc_wready : dn_wready;
    assign up_bvalid = use_htif ? loc_bvalid : dn_bvalid;
    assign up_arready = use_htif ? loc_arready : dn_arready;
    assign up_rvalid = use_htif ? loc_rvalid : dn_rvalid;
    assign up_rdata = use_htif ? loc_rdata : dn_rdata;
    assign up_rlast = use_htif ? loc_rlast : dn_rlast;

    // downstream side, UART requests are always single beat
    assign dn_awaddr = use_htif ? ua_awaddr : up_awaddr;
    assign dn_awlen = use_htif ? '0 : up_awlen;
    assign dn_awvalid = use_htif ? ua_awvalid : up_awvalid;
    assign dn_wdata = use_htif ? ua_wdata : up_wdata;
    assign dn_wstrb = use_htif ? ua_wstrb : up_wstrb;
    assign dn_wlast = use_htif ? ua_wlast : up_wlast;
    assign dn_wvalid = use_htif ? ua_wvalid : up_wvalid;
    assign dn_bready = use_htif ? ua_bready : up_bready;
    assign dn_araddr = use_htif ? ua_araddr : up_araddr;
    assign dn_arlen = use_htif ? '0 : up_arlen;
    assign dn_arvalid = use_htif ? ua_arvalid : up_arvalid;
    assign dn_rready = use_htif ? ua_rready : up_rready;

endmodule

/* hdl/htif_bridge.sv */
// HTIF console bridge
// passes AXI traffic through, serves TOHOST/FROMHOST locally and
// turns console commands into UART-lite transactions
`timescale 1ns/100ps
`include "htif_params.svh"

module htif_bridge (
    input  logic clk,
    input  logic rst,
    // upstream, cache side
    input  htif_pkg::addr_t up_awaddr, up_araddr,
    input  htif_pkg::len_t up_awlen, up_arlen,
    input  logic up_awvalid, up_wvalid, up_wlast, up_bready, up_arvalid, up_rready,
    input  htif_pkg::data_t up_wdata,
    input  htif_pkg::strb_t up_wstrb,
    output logic up_awready, up_wready, up_bvalid, up_arready, up_rvalid, up_rlast,
    output htif_pkg::data_t up_rdata,
    // downstream, memory side
    output htif_pkg::addr_t dn_awaddr, dn_araddr,
    output htif_pkg::len_t dn_awlen, dn_arlen,
    output logic dn_awvalid, dn_wvalid, dn_wlast, dn_bready, dn_arvalid, dn_rready,
    output htif_pkg::data_t dn_wdata,
    output htif_pkg::strb_t dn_wstrb,
    input  logic dn_awready, dn_wready, dn_bvalid, dn_arready, dn_rvalid, dn_rlast,
    input  htif_pkg::data_t dn_rdata
);
    logic use_htif, on_htif, serve, block, done;
    logic poll_start, rx_start, tx_start, rx_load, tx_is_putc, tohost_clr;
    logic fr_empty_read, putc_req, plain_done, rsp_done, rx_valid, tx_full;
    logic loc_arvalid, loc_ar_fr, loc_awvalid, loc_aw_fr, loc_wvalid;
    logic loc_awready, loc_wready, loc_arready, loc_bvalid, loc_rvalid, loc_rlast;
    htif_pkg::data_t loc_rdata, ua_wdata;
    htif_pkg::addr_t ua_araddr, ua_awaddr;
    htif_pkg::strb_t ua_wstrb;
    logic ua_arvalid, ua_awvalid, ua_wvalid, ua_wlast, ua_bready, ua_rready;
    logic [7:0] rx_byte, tohost_byte;

    axi_htif_router router_i (.*);

    htif_ctrl ctrl_i (
        .clk(clk), .rst(rst), .use_htif(use_htif), .fr_empty_read(fr_empty_read),
        .putc_req(putc_req), .plain_done(plain_done), .rsp_done(rsp_done),
        .rx_valid(rx_valid), .tx_full(tx_full), .on_htif(on_htif), .serve(serve),
        .block(block), .poll_start(poll_start), .rx_start(rx_start), .tx_start(tx_start),
        .rx_load(rx_load), .tx_is_putc(tx_is_putc), .tohost_clr(tohost_clr), .done(done)
    );

    htif_regs regs_i (
        .clk(clk), .rst(rst), .serve(serve), .block(block), .rx_load(rx_load),
        .tohost_clr(tohost_clr), .done(done),
        .arvalid(loc_arvalid), .ar_fr(loc_ar_fr), .awvalid(loc_awvalid),
        .aw_fr(loc_aw_fr), .wvalid(loc_wvalid), .wdata(up_wdata),
        .rx_byte(rx_byte), .tohost_byte(tohost_byte),
        .fr_empty_read(fr_empty_read), .putc_req(putc_req), .plain_done(plain_done),
        .awready(loc_awready), .wready(loc_wready), .arready(loc_arready),
        .bvalid(loc_bvalid), .rvalid(loc_rvalid), .rdata(loc_rdata), .rlast(loc_rlast),
        .bready(up_bready), .rready(up_rready)
    );

    uart_lite_master uart_i (
        .clk(clk), .rst(rst), .poll_start(poll_start), .rx_start(rx_start),
        .tx_start(tx_start), .tx_byte(tohost_byte),
        .araddr(ua_araddr), .arvalid(ua_arvalid), .awaddr(ua_awaddr), .awvalid(ua_awvalid),
        .wdata(ua_wdata), .wstrb(ua_wstrb), .wlast(ua_wlast), .wvalid(ua_wvalid),
        .bready(ua_bready), .rready(ua_rready),
        .arready(dn_arready), .awready(dn_awready), .wready(dn_wready),
        .bvalid(dn_bvalid), .rvalid(dn_rvalid), .rdata(dn_rdata),
        .rsp_done(rsp_done), .rx_valid(rx_valid), .tx_full(tx_full), .rx_byte(rx_byte)
    );

endmodule

/* hdl/htif_ctrl.sv */
// HTIF controller
// FSM that follows each HTIF transfer and runs the UART status poll,
// the console transmit and the console receive sequences
`timescale 1ns/100ps

module htif_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic use_htif,
    input  logic fr_empty_read,
    input  logic putc_req,
    input  logic plain_done,
    input  logic rsp_done,
    input  logic rx_valid,
    input  logic tx_full,
    output logic on_htif,
    output logic serve,
    output logic block,
    output logic poll_start,
    output logic rx_start,
    output logic tx_start,
    output logic rx_load,
    output logic tx_is_putc,
    output logic tohost_clr,
    output logic done
);
    htif_pkg::ctrl_state_e state, state_nxt;
    logic putc_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= htif_pkg::IDLE;
            tx_is_putc <= 1'b0;
        end else begin
            state <= state_nxt;
            tx_is_putc <= putc_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        putc_nxt = tx_is_putc;
        poll_start = 1'b0;
        rx_start = 1'b0;
        tx_start = 1'b0;
        rx_load = 1'b0;
        tohost_clr = 1'b0;
        case (state)
            htif_pkg::IDLE: begin
                if (use_htif) state_nxt = htif_pkg::SERVE;
            end
            htif_pkg::SERVE: begin
                if (putc_req) begin
                    putc_nxt = 1'b1;
                    state_nxt = htif_pkg::POLL_AR;
                end else if (fr_empty_read) begin
                    putc_nxt = 1'b0;
                    state_nxt = htif_pkg::POLL_AR;
                end else if (plain_done) begin
                    state_nxt = htif_pkg::RECOVER;
                end
            end
            htif_pkg::POLL_AR: begin
                poll_start = 1'b1;
                state_nxt = htif_pkg::POLL_R;
            end
            htif_pkg::POLL_R: begin
                if (rsp_done) begin
                    if (tx_is_putc)
                        state_nxt = tx_full ? htif_pkg::POLL_AR : htif_pkg::TX_REQ; // retry while full
                    else
                        state_nxt = rx_valid ? htif_pkg::RX_AR : htif_pkg::RECOVER;
                end
            end
            htif_pkg::TX_REQ: begin
                tx_start = 1'b1;
                state_nxt = htif_pkg::TX_B;
            end
            htif_pkg::TX_B: begin
                if (rsp_done) begin
                    tohost_clr = 1'b1; // character handed over
                    state_nxt = htif_pkg::RECOVER;
                end
            end
            htif_pkg::RX_AR: begin
                rx_start = 1'b1;
                state_nxt = htif_pkg::RX_R;
            end
            htif_pkg::RX_R: begin
                if (rsp_done) begin
                    rx_load = 1'b1;
                    state_nxt = htif_pkg::RECOVER;
                end
            end
            default: state_nxt = htif_pkg::IDLE;
        endcase
    end

    assign on_htif = state != htif_pkg::IDLE;
    assign serve = (state == htif_pkg::IDLE) | (state == htif_pkg::SERVE);
    assign block = on_htif & (state != htif_pkg::SERVE); // UART sequence or recovery
    assign done = state == htif_pkg::RECOVER;

endmodule

/* hdl/htif_params.svh */
// HTIF bridge parameters
// addresses, bus widths, UART-lite register layout and console codes
`ifndef HTIF_PARAMS_SVH
`define HTIF_PARAMS_SVH

`define HTIF_ADDR_W 64
`define HTIF_DATA_W 64

`define HTIF_TOHOST_ADDR 64'h0000_0000_8000_1000
`define HTIF_FRHOST_ADDR 64'h0000_0000_8000_1008

`define UART_BASE 64'h0000_0000_1000_0000 // Tx/Rx FIFO
`define UART_STAT_OFS 8
`define UART_RX_VALID_BIT 0
`define UART_TX_FULL_BIT 3
`define UART_TX_STRB 8'h10 // byte lane 4

`define HTIF_DEV_CONSOLE 8'd1
`define HTIF_CMD_PUTC 8'd1
`define HTIF_CMD_GETC 8'd0

`endif

/* hdl/htif_pkg.sv */
// HTIF bridge types
// bus words, the decoded HTIF register word and the controller states
`include "htif_params.svh"

package htif_pkg;

    typedef logic [`HTIF_ADDR_W-1:0] addr_t;
    typedef logic [`HTIF_DATA_W-1:0] data_t;
    typedef logic [`HTIF_DATA_W/8-1:0] strb_t;
    typedef logic [7:0] len_t;

    typedef struct packed {
        logic [7:0] dev;
        logic [7:0] cmd;
        logic [47:0] payload;
    } htif_cmd_t;

    // TOHOST/FROMHOST seen as a bus word or as a command
    typedef union packed {
        data_t raw;
        htif_cmd_t cmd;
    } htif_word_u;

    typedef enum logic [3:0] {
        IDLE,
        SERVE,
        POLL_AR,
        POLL_R,
        TX_REQ,
        TX_B,
        RX_AR,
        RX_R,
        RECOVER
    } ctrl_state_e;

endpackage

/* hdl/htif_regs.sv */
// HTIF register block
// holds TOHOST and FROMHOST and answers single-beat reads and writes
// to them as a local AXI slave
`timescale 1ns/100ps
`include "htif_params.svh"

module htif_regs (
    input  logic clk,
    input  logic rst,
    input  logic serve,
    input  logic block,
    input  logic rx_load,
    input  logic tohost_clr,
    input  logic done,
    input  logic arvalid,
    input  logic ar_fr,
    input  logic awvalid,
    input  logic aw_fr,
    input  logic wvalid,
    input  htif_pkg::data_t wdata,
    input  logic [7:0] rx_byte,
    output logic [7:0] tohost_byte,
    output logic fr_empty_read,
    output logic putc_req,
    output logic plain_done,
    output logic awready,
    output logic wready,
    output logic arready,
    output logic bvalid,
    output logic rvalid,
    output htif_pkg::data_t rdata,
    output logic rlast,
    input  logic bready,
    input  logic rready
);
    htif_pkg::htif_word_u tohost, frhost;
    htif_pkg::data_t wdata_q, wr_val;
    logic ar_got, aw_got, w_got, aw_fr_q, rd_empty_q, wr_fr;
    logic open_acc, ar_hs, aw_hs, w_hs, r_hs, b_hs, wr_fire, tohost_putc;

    assign open_acc = serve & ~block;
    assign arready = open_acc & ~ar_got;
    assign awready = open_acc & ~aw_got;
    assign wready = open_acc & ~w_got;

    assign ar_hs = arvalid & arready;
    assign aw_hs = awvalid & awready;
    assign w_hs = wvalid & wready;
    assign r_hs = rvalid & rready;
    assign b_hs = bvalid & bready;

    // last of AW and W arriving completes the write
    assign wr_fire = (aw_hs | aw_got) & (w_hs | w_got) & ~(aw_got & w_got);
    assign wr_fr = aw_got ? aw_fr_q : aw_fr;
    assign wr_val = w_got ? wdata_q : wdata;

    assign tohost_putc = (tohost.cmd.dev == `HTIF_DEV_CONSOLE)
                       & (tohost.cmd.cmd == `HTIF_CMD_PUTC);
    assign tohost_byte = tohost.cmd.payload[7:0];

    assign fr_empty_read = r_hs & rd_empty_q;
    assign putc_req = b_hs & tohost_putc;
    assign plain_done = (r_hs & ~rd_empty_q) | (b_hs & ~tohost_putc);
    assign rlast = rvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_got <= 1'b0;
            aw_got <= 1'b0;
            w_got <= 1'b0;
            rvalid <= 1'b0;
            bvalid <= 1'b0;
            tohost.raw <= '0;
            frhost.raw <= '0;
        end else begin
            if (done) begin // reopen for the next request
                ar_got <= 1'b0;
                aw_got <= 1'b0;
                w_got <= 1'b0;
            end else begin
                if (ar_hs) ar_got <= 1'b1;
                if (aw_hs) aw_got <= 1'b1;
                if (w_hs) w_got <= 1'b1;
            end
            if (ar_hs) rvalid <= 1'b1;
            else if (r_hs) rvalid <= 1'b0;
            if (wr_fire) bvalid <= 1'b1;
            else if (b_hs) bvalid <= 1'b0;
            if (wr_fire & wr_fr) frhost.raw <= wr_val;
            if (wr_fire & ~wr_fr) tohost.raw <= wr_val;
            else if (tohost_clr | b_hs & ~aw_fr_q & ~tohost_putc) tohost.raw <= '0;
            if (rx_load) frhost.cmd <= '{`HTIF_DEV_CONSOLE, `HTIF_CMD_GETC, 48'(rx_byte)};
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) aw_fr_q <= aw_fr;
        if (w_hs) wdata_q <= wdata;
        if (ar_hs) begin
            rdata <= ar_fr ? frhost.raw : tohost.raw;
            rd_empty_q <= ar_fr & (frhost.raw == '0); // triggers an Rx poll
        end
    end

endmodule

/* hdl/uart_lite_master.sv */
// UART-lite master
// single-beat status reads, Rx FIFO reads and Tx FIFO writes
// on the downstream bus, with the status bits decoded
`timescale 1ns/100ps
`include "htif_params.svh"

module uart_lite_master (
    input  logic clk,
    input  logic rst,
    input  logic poll_start,
    input  logic rx_start,
    input  logic tx_start,
    input  logic [7:0] tx_byte,
    output htif_pkg::addr_t araddr,
    output logic arvalid,
    output htif_pkg::addr_t awaddr,
    output logic awvalid,
    output htif_pkg::data_t wdata,
    output htif_pkg::strb_t wstrb,
    output logic wlast,
    output logic wvalid,
    output logic bready,
    output logic rready,
    input  logic arready,
    input  logic awready,
    input  logic wready,
    input  logic bvalid,
    input  logic rvalid,
    input  htif_pkg::data_t rdata,
    output logic rsp_done,
    output logic rx_valid,
    output logic tx_full,
    output logic [7:0] rx_byte
);
    logic rd_stat, r_hs, b_hs;
    logic [7:0] stat_q, stat;

    assign r_hs = rvalid & rready;
    assign b_hs = bvalid & bready;

    assign araddr = rd_stat ? `UART_BASE + 64'(`UART_STAT_OFS) : `UART_BASE;
    assign awaddr = `UART_BASE;
    assign wdata = {24'd0, tx_byte, 32'd0}; // character in lane 4
    assign wstrb = `UART_TX_STRB;
    assign wlast = 1'b1;

    // status is visible in the cycle of its response
    assign stat = (r_hs & rd_stat) ? rdata[7:0] : stat_q;
    assign rx_valid = stat[`UART_RX_VALID_BIT];
    assign tx_full = stat[`UART_TX_FULL_BIT];
    assign rx_byte = rdata[7:0];
    assign rsp_done = r_hs | b_hs;

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid <= 1'b0;
            bready <= 1'b0;
            rready <= 1'b0;
            rd_stat <= 1'b0;
            stat_q <= '0;
        end else begin
            if (poll_start | rx_start) begin
                arvalid <= 1'b1;
                rd_stat <= poll_start;
            end else if (arvalid & arready) begin
                arvalid <= 1'b0;
                rready <= 1'b1;
            end
            if (r_hs) begin
                rready <= 1'b0;
                if (rd_stat) stat_q <= rdata[7:0];
            end
            if (tx_start) begin
                awvalid <= 1'b1;
                wvalid <= 1'b1;
            end else begin
                if (awready) awvalid <= 1'b0;
                if (wready) wvalid <= 1'b0;
            end
            if ((awvalid | wvalid) & (~awvalid | awready) & (~wvalid | wready))
                bready <= 1'b1; // both AW and W accepted
            else if (b_hs)
                bready <= 1'b0;
        end
    end

endmodule

/* tests/htif_bridge_checker.sv */
// HTIF bridge checker
// downstream channel stability, UART write format and response state after reset
`timescale 1ns/100ps
`include "htif_params.svh"

module htif_bridge_checker (
    input logic clk,
    input logic rst,
    input logic dn_arvalid, dn_arready, dn_awvalid, dn_awready, dn_wvalid, dn_wready,
    input htif_pkg::addr_t dn_araddr, dn_awaddr,
    input htif_pkg::data_t dn_wdata,
    input htif_pkg::strb_t dn_wstrb,
    input logic up_bvalid, up_rvalid
);
    int fails = 0;

    ar_hold: assert property (@(posedge clk) disable iff (rst)
        dn_arvalid && !dn_arready |=> dn_arvalid && $stable(dn_araddr))
        else begin
            $error("dn AR valid dropped or address changed before ready");
            fails++;
        end

    aw_hold: assert property (@(posedge clk) disable iff (rst)
        dn_awvalid && !dn_awready |=> dn_awvalid && $stable(dn_awaddr))
        else begin
            $error("dn AW valid dropped or address changed before ready");
            fails++;
        end

    w_hold: assert property (@(posedge clk) disable iff (rst)
        dn_wvalid && !dn_wready |=> dn_wvalid && $stable(dn_wdata) && $stable(dn_wstrb))
        else begin
            $error("dn W valid dropped or payload changed before ready");
            fails++;
        end

    // FIFO write always uses the Tx byte lane
    tx_strb: assert property (@(posedge clk) disable iff (rst)
        dn_awvalid && dn_wvalid && dn_awaddr == `UART_BASE |-> dn_wstrb == `UART_TX_STRB)
        else begin
            $error("UART FIFO write with wrong strobe");
            fails++;
        end

    rsp_after_rst: assert property (@(posedge clk)
        rst |=> !up_bvalid && !up_rvalid)
        else begin
            $error("upstream response valid high right after reset");
            fails++;
        end

endmodule

bind htif_bridge htif_bridge_checker chk_i (.*);

/* tests/htif_bridge_tb.sv */
// HTIF bridge testbench
// upstream master, downstream memory and UART-lite model, table-driven checks
`timescale 1ns/100ps
`include "htif_params.svh"

module htif_bridge_tb;
    logic clk, rst;
    htif_pkg::addr_t up_awaddr, up_araddr, dn_awaddr, dn_araddr;
    htif_pkg::len_t up_awlen, up_arlen, dn_awlen, dn_arlen;
    logic up_awvalid, up_wvalid, up_wlast, up_bready, up_arvalid, up_rready;
    logic up_awready, up_wready, up_bvalid, up_arready, up_rvalid, up_rlast;
    logic dn_awvalid, dn_wvalid, dn_wlast, dn_bready, dn_arvalid, dn_rready;
    logic dn_awready, dn_wready, dn_bvalid, dn_arready, dn_rvalid, dn_rlast;
    htif_pkg::data_t up_wdata, up_rdata, dn_wdata, dn_rdata;
    htif_pkg::strb_t up_wstrb, dn_wstrb;

    // table of rows
    string row_name[32];
    logic row_wr[32], row_rx[32];
    htif_pkg::addr_t row_addr[32];
    htif_pkg::data_t row_wdata[32], row_exp[32];
    logic [7:0] row_rxb[32], row_txb[32];
    int row_full[32];
    int num_rows = 0;
    int cycles = 0;
    int errors = 0;
    logic [31:0] lcg_state = 32'd39;

    // downstream model state
    htif_pkg::data_t mem[htif_pkg::addr_t];
    logic [7:0] rx_q[$];
    int full_left = 0;
    int stat_reads, fifo_reads, tx_writes;
    htif_pkg::data_t tx_data, pt_data, rd_data, wd_q;
    htif_pkg::strb_t pt_strb, ws_q;
    htif_pkg::addr_t pt_addr, aw_q;
    htif_pkg::len_t ar_len_q, aw_len_q;
    logic aw_got, w_got, rd_pend, wr_pend, wl_q;

    htif_bridge htif_bridge_i (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic htif_pkg::data_t rand_word();
        htif_pkg::data_t w;
        lcg_state = lcg_next(lcg_state);
        w[63:32] = lcg_state;
        lcg_state = lcg_next(lcg_state);
        w[31:0] = lcg_state;
        return w;
    endfunction

    task automatic add_row(input string name, input logic wr, input htif_pkg::addr_t a,
                           input htif_pkg::data_t d, input logic rx, input logic [7:0] rxb,
                           input int full, input htif_pkg::data_t exp, input logic [7:0] txb);
        row_name[num_rows] = name;
        row_wr[num_rows] = wr;
        row_addr[num_rows] = a;
        row_wdata[num_rows] = d;
        row_rx[num_rows] = rx;
        row_rxb[num_rows] = rxb;
        row_full[num_rows] = full;
        row_exp[num_rows] = exp;
        row_txb[num_rows] = txb;
        num_rows++;
    endtask

    task automatic report_mismatch(input string name, input htif_pkg::data_t exp,
                                   input htif_pkg::data_t act);
        errors++;
        $display("CHECK FAILED: %s expected %h actual %h", name, exp, act);
        $display("CHECKS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    always @(posedge clk) begin
        cycles++;
        if (num_rows > 0 && cycles > 200 * num_rows) begin
            $display("timeout: no response within %0d cycles", 200 * num_rows);
            $display("CHECKS FAILED");
            $fatal(1, "run did not finish");
        end
    end

    always @(negedge clk) begin
        if (htif_bridge_i.chk_i.fails != 0) begin
            $display("a bound protocol assertion failed");
            $display("CHECKS FAILED");
            $fatal(1, "protocol assertion failed");
        end
    end

    task automatic model_read(input htif_pkg::addr_t a, output htif_pkg::data_t d);
        d = '0;
        if (a == `UART_BASE + 64'(`UART_STAT_OFS)) begin
            stat_reads++;
            d[`UART_TX_FULL_BIT] = full_left > 0;
            d[`UART_RX_VALID_BIT] = rx_q.size() > 0;
            if (full_left > 0) full_left--;
        end else if (a == `UART_BASE) begin
            fifo_reads++;
            if (rx_q.size() > 0) d[7:0] = rx_q.pop_front();
        end else begin
            d = mem.exists(a) ? mem[a] : ~a; // fill pattern from the address
        end
    endtask

    task automatic model_write(input htif_pkg::addr_t a, input htif_pkg::data_t d,
                               input htif_pkg::strb_t s);
        htif_pkg::data_t old;
        if (a == `UART_BASE) begin
            tx_writes++;
            tx_data = d;
        end else begin
            old = mem.exists(a) ? mem[a] : ~a;
            for (int b = 0; b < 8; b++)
                if (s[b]) old[b*8 +: 8] = d[b*8 +: 8];
            mem[a] = old;
            pt_addr = a;
            pt_data = d;
            pt_strb = s;
        end
    endtask

    // downstream slave, readys stall in a fixed pattern, one response at a time
    always @(posedge clk) begin
        if (rst) begin
            stat_reads = 0;
            fifo_reads = 0;
            tx_writes = 0;
            aw_got = 0;
            w_got = 0;
            rd_pend = 0;
            wr_pend = 0;
        end else begin
            if (dn_rvalid && dn_rready) rd_pend = 0;
            if (dn_bvalid && dn_bready) wr_pend = 0;
            if (dn_arvalid && dn_arready) begin
                model_read(dn_araddr, rd_data);
                ar_len_q = dn_arlen;
                rd_pend = 1;
            end
            if (dn_awvalid && dn_awready) begin
                aw_q = dn_awaddr;
                aw_len_q = dn_awlen;
                aw_got = 1;
            end
            if (dn_wvalid && dn_wready) begin
                wd_q = dn_wdata;
                ws_q = dn_wstrb;
                wl_q = dn_wlast;
                w_got = 1;
            end
            if (aw_got && w_got) begin
                model_write(aw_q, wd_q, ws_q);
                aw_got = 0;
                w_got = 0;
                wr_pend = 1;
            end
        end
        #1;
        dn_arready = cycles % 3 != 0;
        dn_awready = cycles % 4 != 1;
        dn_wready = cycles % 5 != 2;
        dn_rvalid = rd_pend;
        dn_rlast = rd_pend;
        dn_rdata = rd_data;
        dn_bvalid = wr_pend;
    end

    task automatic write_up(input htif_pkg::addr_t a, input htif_pkg::data_t d);
        logic aw_ok, w_ok, aw_now, w_now;
        aw_ok = 0;
        w_ok = 0;
        up_awaddr = a;
        up_awlen = '0;
        up_awvalid = 1;
        up_wdata = d;
        up_wstrb = '1;
        up_wlast = 1;
        up_wvalid = 1;
        up_bready = 1;
        while (!(aw_ok && w_ok)) begin
            @(negedge clk);
            aw_now = up_awvalid && up_awready;
            w_now = up_wvalid && up_wready;
            @(posedge clk);
            #1;
            if (aw_now) begin
                up_awvalid = 0;
                aw_ok = 1;
            end
            if (w_now) begin
                up_wvalid = 0;
                w_ok = 1;
            end
        end
        do @(negedge clk); while (!up_bvalid);
        @(posedge clk);
        #1 up_bready = 0;
    endtask

    task automatic read_up(input htif_pkg::addr_t a, output htif_pkg::data_t d,
                           output logic last);
        up_araddr = a;
        up_arlen = '0;
        up_arvalid = 1;
        up_rready = 1;
        do @(negedge clk); while (!up_arready);
        @(posedge clk);
        #1 up_arvalid = 0;
        do @(negedge clk); while (!up_rvalid);
        d = up_rdata;
        last = up_rlast;
        @(posedge clk);
        #1 up_rready = 0;
    endtask

    initial begin
        htif_pkg::data_t r0, r1, got, putc_a, putc_z, getc_c;
        int exp_stat, exp_fifo, exp_tx;
        logic putc, empty_rd, htif_addr, got_last;
        r0 = rand_word();
        r1 = rand_word();
        putc_a = {`HTIF_DEV_CONSOLE, `HTIF_CMD_PUTC, 48'h41};
        putc_z = {`HTIF_DEV_CONSOLE, `HTIF_CMD_PUTC, 48'h5a};
        getc_c = {`HTIF_DEV_CONSOLE, `HTIF_CMD_GETC, 48'h63};
        //      name               wr addr               wdata   rx rxb   full exp   txb
        add_row("pt_wr_a",          1, 64'h8000_2000,    r0,     0, 0,     0, 0,      0);
        add_row("pt_rd_a",          0, 64'h8000_2000,    0,      0, 0,     0, r0,     0);
        add_row("pt_rd_fill",       0, 64'h8000_3008,    0,      0, 0,     0, ~64'h8000_3008, 0);
        add_row("to_wr_plain",      1, `HTIF_TOHOST_ADDR, 64'h1, 0, 0,     0, 0,      0);
        add_row("to_rd_zero",       0, `HTIF_TOHOST_ADDR, 0,     0, 0,     0, 0,      0);
        add_row("to_wr_putc",       1, `HTIF_TOHOST_ADDR, putc_a, 0, 0,    0, 0,      8'h41);
        add_row("to_rd_after_putc", 0, `HTIF_TOHOST_ADDR, 0,     0, 0,     0, 0,      0);
        add_row("to_wr_putc_full",  1, `HTIF_TOHOST_ADDR, putc_z, 0, 0,    2, 0,      8'h5a);
        add_row("to_rd_after_full", 0, `HTIF_TOHOST_ADDR, 0,     0, 0,     0, 0,      0);
        add_row("fr_rd_empty_rx",   0, `HTIF_FRHOST_ADDR, 0,     1, 8'h63, 0, 0,      0);
        add_row("fr_rd_loaded",     0, `HTIF_FRHOST_ADDR, 0,     0, 0,     0, getc_c, 0);
        add_row("fr_rd_again",      0, `HTIF_FRHOST_ADDR, 0,     0, 0,     0, getc_c, 0);
        add_row("fr_wr_zero",       1, `HTIF_FRHOST_ADDR, 0,     0, 0,     0, 0,      0);
        add_row("fr_rd_empty",      0, `HTIF_FRHOST_ADDR, 0,     0, 0,     0, 0,      0);
        add_row("fr_rd_still",      0, `HTIF_FRHOST_ADDR, 0,     0, 0,     0, 0,      0);
        add_row("pt_wr_b",          1, 64'h8000_2008,    r1,     0, 0,     0, 0,      0);
        add_row("pt_rd_b",          0, 64'h8000_2008,    0,      0, 0,     0, r1,     0);

        rst = 1;
        up_awaddr = '0;
        up_awlen = '0;
        up_awvalid = 0;
        up_wdata = '0;
        up_wstrb = '0;
        up_wlast = 0;
        up_wvalid = 0;
        up_bready = 0;
        up_araddr = '0;
        up_arlen = '0;
        up_arvalid = 0;
        up_rready = 0;
        dn_awready = 1;
        dn_wready = 1;
        dn_arready = 1;
        dn_bvalid = 0;
        dn_rvalid = 0;
        dn_rlast = 0;
        dn_rdata = '0;
        exp_stat = 0;
        exp_fifo = 0;
        exp_tx = 0;
        repeat (2) @(posedge clk);
        #1 rst = 0;

        for (int i = 0; i < num_rows; i++) begin
            if (row_rx[i]) rx_q.push_back(row_rxb[i]);
            full_left = row_full[i];
            htif_addr = row_addr[i] == `HTIF_TOHOST_ADDR || row_addr[i] == `HTIF_FRHOST_ADDR;
            putc = row_wr[i] && row_addr[i] == `HTIF_TOHOST_ADDR
                && row_wdata[i][63:56] == `HTIF_DEV_CONSOLE
                && row_wdata[i][55:48] == `HTIF_CMD_PUTC;
            empty_rd = !row_wr[i] && row_addr[i] == `HTIF_FRHOST_ADDR && row_exp[i] == '0;
            if (row_wr[i]) begin
                write_up(row_addr[i], row_wdata[i]);
            end else begin
                read_up(row_addr[i], got, got_last);
                assert (got == row_exp[i]) else report_mismatch(row_name[i], row_exp[i], got);
                assert (got_last == 1'b1)
                    else report_mismatch(row_name[i], 64'h1, 64'(got_last));
            end
            if (row_wr[i] && !htif_addr) begin
                assert (pt_addr == row_addr[i])
                    else report_mismatch(row_name[i], row_addr[i], pt_addr);
                assert (pt_data == row_wdata[i])
                    else report_mismatch(row_name[i], row_wdata[i], pt_data);
                assert (pt_strb == 8'hff) else report_mismatch(row_name[i], 64'hff, 64'(pt_strb));
                assert (aw_len_q == '0)
                    else report_mismatch(row_name[i], 64'h0, 64'(aw_len_q));
                assert (wl_q == 1'b1) else report_mismatch(row_name[i], 64'h1, 64'(wl_q));
            end
            if (!row_wr[i] && !htif_addr) begin
                assert (ar_len_q == '0)
                    else report_mismatch(row_name[i], 64'h0, 64'(ar_len_q));
            end
            if (putc) begin
                exp_stat += row_full[i] + 1; // one extra poll sees room
                exp_tx++;
                while (tx_writes != exp_tx) begin
                    @(posedge clk);
                    #1;
                end
                assert (tx_data[39:32] == row_txb[i])
                    else report_mismatch(row_name[i], 64'(row_txb[i]), 64'(tx_data[39:32]));
            end
            if (empty_rd) begin
                exp_stat++;
                while (stat_reads != exp_stat) begin
                    @(posedge clk);
                    #1;
                end
                if (row_rx[i]) begin
                    exp_fifo++;
                    while (fifo_reads != exp_fifo) begin
                        @(posedge clk);
                        #1;
                    end
                end
            end
            assert (stat_reads == exp_stat)
                else report_mismatch(row_name[i], 64'(exp_stat), 64'(stat_reads));
            assert (fifo_reads == exp_fifo)
                else report_mismatch(row_name[i], 64'(exp_fifo), 64'(fifo_reads));
            assert (tx_writes == exp_tx)
                else report_mismatch(row_name[i], 64'(exp_tx), 64'(tx_writes));
        end

        if (errors == 0 && htif_bridge_i.chk_i.fails == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "run ended with errors");
        end
    end

endmodule
